// ==== include/nand_defs.svh ====
// Bus timing is counted in clk cycles and each value must be at least 1.
// The ID length and the Wishbone widths are fixed by the register map.
`ifndef NAND_DEFS_SVH
`define NAND_DEFS_SVH

// ****************************************
// NAND bus timing
// ****************************************

// Cycles before, during and after each active-low strobe pulse.
`define NAND_T_SETUP 2
`define NAND_T_PULSE 3
`define NAND_T_HOLD 2

// Status reads allowed before the sequencer gives up on the device.
`define NAND_POLL_MAX 16

// Number of ID bytes read after the address cycle.
`define NAND_ID_BYTES 4

// ****************************************
// Wishbone
// ****************************************
`define WB_ADR_W 4
`define WB_DAT_W 32

`endif

// ==== hdl/nand_pkg.sv ====
// Bus-cycle and pin types for a raw 8-bit NAND device.
// Only the reset, status and read-ID commands are defined.
package nand_pkg;

    typedef enum logic [1:0] {
        CYC_CMD  = 2'd0,
        CYC_ADDR = 2'd1,
        CYC_READ = 2'd2
    } cycle_kind_t;

    // One bus cycle request. The data byte is ignored for reads.
    typedef struct packed {
        cycle_kind_t kind;
        logic [7:0]  data;
    } nand_cycle_t;

    typedef struct packed {
        logic       ce_n;
        logic       cle;
        logic       ale;
        logic       we_n;
        logic       re_n;
        logic       dq_oe;
        logic [7:0] dq_out;
    } nand_pins_t;

    localparam logic [7:0] CMD_RESET   = 8'hff;
    localparam logic [7:0] CMD_STATUS  = 8'h70;
    localparam logic [7:0] CMD_READ_ID = 8'h90;

    // Ready bit of the status byte.
    localparam int STATUS_RDY_BIT = 6;

    // Pin levels while no bus cycle is in progress.
    localparam nand_pins_t PINS_IDLE = '{
        ce_n:   1'b1,
        cle:    1'b0,
        ale:    1'b0,
        we_n:   1'b1,
        re_n:   1'b1,
        dq_oe:  1'b0,
        dq_out: 8'h00
    };

endpackage

// ==== hdl/wb_pkg.sv ====
// Wishbone classic bus types and the register map of the ID reader.
`include "nand_defs.svh"

package wb_pkg;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_ADR_W-1:0] adr;
        logic [`WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    localparam logic [`WB_ADR_W-1:0] REG_CTRL   = `WB_ADR_W'd0;
    localparam logic [`WB_ADR_W-1:0] REG_STATUS = `WB_ADR_W'd1;
    localparam logic [`WB_ADR_W-1:0] REG_ID     = `WB_ADR_W'd2;

    // Field positions inside REG_CTRL and REG_STATUS.
    localparam int CTRL_START_BIT   = 0;
    localparam int CTRL_ID_LSB      = 8;
    localparam int STAT_BUSY_BIT    = 0;
    localparam int STAT_DONE_BIT    = 1;
    localparam int STAT_TIMEOUT_BIT = 2;
    localparam int STAT_BYTE_LSB    = 8;

endpackage

// ==== hdl/nand_phy.sv ====
// Runs one NAND bus cycle at a time with fixed setup, pulse and hold counts.
// Read data is sampled on the last cycle of the re_n pulse.
`timescale 1ns/1ps
`include "nand_defs.svh"

module nand_phy (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cyc_valid,
    input  nand_pkg::nand_cycle_t cyc,
    output logic                  cyc_ready,
    output logic                  done,
    output logic [7:0]            rd_data,
    output nand_pkg::nand_pins_t  nand_pins,
    input  logic [7:0]            dq_in
);

    localparam int T_SETUP   = `NAND_T_SETUP;
    localparam int PULSE_END = T_SETUP + `NAND_T_PULSE;
    localparam int T_TOTAL   = PULSE_END + `NAND_T_HOLD;
    localparam int CNT_W     = $clog2(T_TOTAL + 1);

    logic                  active_q;
    logic [CNT_W-1:0]      cnt_q;
    nand_pkg::nand_cycle_t cur_q;
    logic [7:0]            rd_data_q;
    logic                  in_pulse;
    logic                  last_pulse;
    logic                  last_cnt;
    logic                  is_read;

    assign in_pulse   = active_q && (cnt_q >= CNT_W'(T_SETUP)) && (cnt_q < CNT_W'(PULSE_END));
    assign last_pulse = active_q && (cnt_q == CNT_W'(PULSE_END - 1));
    assign last_cnt   = active_q && (cnt_q == CNT_W'(T_TOTAL - 1));
    assign is_read    = (cur_q.kind == nand_pkg::CYC_READ);

    assign cyc_ready = !active_q;
    assign done      = last_cnt;
    assign rd_data   = rd_data_q;

    // Phase counter. It runs from acceptance until the last hold cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (cyc_valid && cyc_ready) begin
            active_q <= 1'b1;
            cnt_q    <= '0;
        end else if (active_q) begin
            if (last_cnt) begin
                active_q <= 1'b0;
            end
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cyc_valid && cyc_ready) begin
            cur_q <= cyc;
        end
        if (last_pulse && is_read) begin
            rd_data_q <= dq_in;
        end
    end

    // ****************************************
    // Pin decode
    // ****************************************

    // Latch enables and chip enable cover the whole cycle, so the strobe
    // edges always see stable control and data lines.
    always_comb begin
        nand_pins = nand_pkg::PINS_IDLE;
        if (active_q) begin
            nand_pins.ce_n   = 1'b0;
            nand_pins.cle    = (cur_q.kind == nand_pkg::CYC_CMD);
            nand_pins.ale    = (cur_q.kind == nand_pkg::CYC_ADDR);
            nand_pins.dq_oe  = !is_read;
            nand_pins.dq_out = cur_q.data;
            nand_pins.we_n   = !(in_pulse && !is_read);
            nand_pins.re_n   = !(in_pulse && is_read);
        end
    end

    // The requester keeps one cycle in flight and waits for done.
    a_req_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        active_q |-> !cyc_valid);

endmodule

// ==== hdl/nand_id_seq.sv ====
// Runs reset, status polling and read-ID as a chain of single bus cycles.
// A start pulse is only taken while idle; the ID address is latched then.
`timescale 1ns/1ps
`include "nand_defs.svh"

module nand_id_seq (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [7:0]            id_addr,
    output logic                  busy,
    output logic                  byte_valid,
    output logic [1:0]            byte_idx,
    output logic [7:0]            byte_data,
    output logic                  finish,
    output logic                  timeout,
    output logic [7:0]            status_byte,
    output logic                  cyc_valid,
    output nand_pkg::nand_cycle_t cyc,
    input  logic                  cyc_ready,
    input  logic                  done,
    input  logic [7:0]            rd_data
);

    localparam int POLL_W = $clog2(`NAND_POLL_MAX + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RESET,
        ST_POLL,
        ST_ID,
        ST_READ
    } state_t;

    state_t            state_q;
    logic              step_q;
    logic              wait_q;
    logic [POLL_W-1:0] poll_q;
    logic [1:0]        idx_q;
    logic              finish_q;
    logic              timeout_q;
    logic [7:0]        addr_q;
    logic [7:0]        status_q;
    logic              ready_bit;

    assign ready_bit = rd_data[nand_pkg::STATUS_RDY_BIT];

    assign busy        = (state_q != ST_IDLE) || finish_q;
    assign byte_valid  = done && (state_q == ST_READ);
    assign byte_idx    = idx_q;
    assign byte_data   = rd_data;
    assign finish      = finish_q;
    assign timeout     = timeout_q;
    assign status_byte = status_q;
    assign cyc_valid   = (state_q != ST_IDLE) && !wait_q;

    // POLL and ID each take two bus cycles, told apart by step_q.
    always_comb begin
        cyc = '{kind: nand_pkg::CYC_CMD, data: nand_pkg::CMD_RESET};
        case (state_q)
            ST_POLL: begin
                if (step_q) begin
                    cyc = '{kind: nand_pkg::CYC_READ, data: 8'h00};
                end else begin
                    cyc = '{kind: nand_pkg::CYC_CMD, data: nand_pkg::CMD_STATUS};
                end
            end
            ST_ID: begin
                if (step_q) begin
                    cyc = '{kind: nand_pkg::CYC_ADDR, data: addr_q};
                end else begin
                    cyc = '{kind: nand_pkg::CYC_CMD, data: nand_pkg::CMD_READ_ID};
                end
            end
            ST_READ: cyc = '{kind: nand_pkg::CYC_READ, data: 8'h00};
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= ST_IDLE;
            step_q    <= 1'b0;
            wait_q    <= 1'b0;
            poll_q    <= '0;
            idx_q     <= '0;
            finish_q  <= 1'b0;
            timeout_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (cyc_valid && cyc_ready) begin
                wait_q <= 1'b1;
            end else if (done) begin
                wait_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (start && !finish_q) begin
                        state_q   <= ST_RESET;
                        step_q    <= 1'b0;
                        poll_q    <= '0;
                        idx_q     <= '0;
                        timeout_q <= 1'b0;
                    end
                end
                ST_RESET: begin
                    if (done) begin
                        state_q <= ST_POLL;
                    end
                end
                ST_POLL: begin
                    if (done) begin
                        step_q <= !step_q;
                        if (step_q && ready_bit) begin
                            state_q <= ST_ID;
                        end else if (step_q && (poll_q == POLL_W'(`NAND_POLL_MAX - 1))) begin
                            // Give up and skip the ID phase.
                            state_q   <= ST_IDLE;
                            finish_q  <= 1'b1;
                            timeout_q <= 1'b1;
                        end else if (step_q) begin
                            poll_q <= poll_q + 1'b1;
                        end
                    end
                end
                ST_ID: begin
                    if (done) begin
                        step_q <= !step_q;
                        if (step_q) begin
                            state_q <= ST_READ;
                        end
                    end
                end
                ST_READ: begin
                    if (done) begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == 2'(`NAND_ID_BYTES - 1)) begin
                            state_q  <= ST_IDLE;
                            finish_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && start && !finish_q) begin
            addr_q <= id_addr;
        end
        if (done && (state_q == ST_POLL) && step_q) begin
            status_q <= rd_data;
        end
    end

    // The phy may only answer a cycle that is in flight.
    a_done_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> wait_q);

endmodule

// ==== hdl/nand_wb_regs.sv ====
// Wishbone classic slave with one wait state on every access.
// REG_STATUS and REG_ID are read only; writes to them are acknowledged.
`timescale 1ns/1ps
`include "nand_defs.svh"

module nand_wb_regs (
    input  logic            clk,
    input  logic            arst_n,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp,
    output logic            start,
    output logic [7:0]      id_addr,
    input  logic            busy,
    input  logic            byte_valid,
    input  logic [1:0]      byte_idx,
    input  logic [7:0]      byte_data,
    input  logic            finish,
    input  logic            timeout,
    input  logic [7:0]      status_byte
);

    logic                 ack_q;
    logic [`WB_DAT_W-1:0] rdata_q;
    logic [`WB_DAT_W-1:0] rd_mux;
    logic                 start_q;
    logic [7:0]           id_addr_q;
    logic                 done_q;
    logic                 timeout_q;
    logic [7:0]           status_q;
    logic [`WB_DAT_W-1:0] id_q;
    logic                 req;
    logic                 wr_ctrl;

    // A new access is taken only when no ack is out.
    assign req     = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_ctrl = req && wb_req.we && (wb_req.adr == wb_pkg::REG_CTRL);

    assign wb_rsp  = '{ack: ack_q, dat: rdata_q};
    assign start   = start_q;
    assign id_addr = id_addr_q;

    always_comb begin
        rd_mux = '0;
        case (wb_req.adr)
            wb_pkg::REG_CTRL: rd_mux[wb_pkg::CTRL_ID_LSB +: 8] = id_addr_q;
            wb_pkg::REG_STATUS: begin
                rd_mux[wb_pkg::STAT_BUSY_BIT]      = busy;
                rd_mux[wb_pkg::STAT_DONE_BIT]      = done_q;
                rd_mux[wb_pkg::STAT_TIMEOUT_BIT]   = timeout_q;
                rd_mux[wb_pkg::STAT_BYTE_LSB +: 8] = status_q;
            end
            wb_pkg::REG_ID: rd_mux = id_q;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q     <= 1'b0;
            rdata_q   <= '0;
            start_q   <= 1'b0;
            id_addr_q <= '0;
            done_q    <= 1'b0;
            timeout_q <= 1'b0;
            status_q  <= '0;
            id_q      <= '0;
        end else begin
            ack_q   <= req;
            start_q <= wr_ctrl && wb_req.dat[wb_pkg::CTRL_START_BIT];
            if (wr_ctrl) begin
                id_addr_q <= wb_req.dat[wb_pkg::CTRL_ID_LSB +: 8];
            end
            if (req && !wb_req.we) begin
                rdata_q <= rd_mux;
            end
            // Flags clear only on a start the sequencer takes.
            if (start_q && !busy) begin
                done_q    <= 1'b0;
                timeout_q <= 1'b0;
            end
            if (finish) begin
                done_q    <= 1'b1;
                timeout_q <= timeout;
                status_q  <= status_byte;
            end
            if (byte_valid) begin
                id_q[{byte_idx, 3'b000} +: 8] <= byte_data;
            end
        end
    end

    // ID bytes may only arrive while a run is in progress.
    a_byte_in_run: assert property (@(posedge clk) disable iff (!arst_n)
        byte_valid |-> busy);

endmodule

// ==== hdl/nand_id_top.sv ====
// NAND ID reader with a Wishbone classic register port.
// The host starts a run through REG_CTRL and polls REG_STATUS for done.
`timescale 1ns/1ps

module nand_id_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  wb_pkg::wb_req_t      wb_req,
    output wb_pkg::wb_rsp_t      wb_rsp,
    output nand_pkg::nand_pins_t nand_pins,
    input  logic [7:0]           dq_in
);

    logic                  start;
    logic [7:0]            id_addr;
    logic                  busy;
    logic                  byte_valid;
    logic [1:0]            byte_idx;
    logic [7:0]            byte_data;
    logic                  finish;
    logic                  timeout;
    logic [7:0]            status_byte;
    logic                  cyc_valid;
    nand_pkg::nand_cycle_t cyc;
    logic                  cyc_ready;
    logic                  done;
    logic [7:0]            rd_data;

    nand_wb_regs i_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .start       (start),
        .id_addr     (id_addr),
        .busy        (busy),
        .byte_valid  (byte_valid),
        .byte_idx    (byte_idx),
        .byte_data   (byte_data),
        .finish      (finish),
        .timeout     (timeout),
        .status_byte (status_byte)
    );

    nand_id_seq i_seq (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .id_addr     (id_addr),
        .busy        (busy),
        .byte_valid  (byte_valid),
        .byte_idx    (byte_idx),
        .byte_data   (byte_data),
        .finish      (finish),
        .timeout     (timeout),
        .status_byte (status_byte),
        .cyc_valid   (cyc_valid),
        .cyc         (cyc),
        .cyc_ready   (cyc_ready),
        .done        (done),
        .rd_data     (rd_data)
    );

    nand_phy i_phy (
        .clk       (clk),
        .arst_n    (arst_n),
        .cyc_valid (cyc_valid),
        .cyc       (cyc),
        .cyc_ready (cyc_ready),
        .done      (done),
        .rd_data   (rd_data),
        .nand_pins (nand_pins),
        .dq_in     (dq_in)
    );

endmodule

// ==== dv/nand_flash_model.sv ====
// Behavioural NAND device that reacts to strobe edges only, with no ready/busy pin.
// It knows the reset, status and read-ID commands and counts overlapping strobes.
`timescale 1ns/1ps

module nand_flash_model (
    input  nand_pkg::nand_pins_t nand_pins,
    output logic [7:0]           dq_in,
    input  logic [7:0]           busy_polls,
    input  logic [31:0]          manuf_id,
    input  logic [31:0]          sig_id,
    output int                   overlap_cnt
);

    localparam logic [7:0] OP_RESET     = 8'hff;
    localparam logic [7:0] OP_STATUS    = 8'h70;
    localparam logic [7:0] OP_READ_ID   = 8'h90;
    localparam logic [7:0] STATUS_BUSY  = 8'h80;
    localparam logic [7:0] STATUS_READY = 8'he0;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_STATUS,
        MODE_ID
    } mode_t;

    logic       we_n;
    logic       re_n;
    mode_t      mode;
    logic [7:0] polls_left;
    logic [7:0] id_addr;
    logic [1:0] id_idx;

    assign we_n = nand_pins.we_n;
    assign re_n = nand_pins.re_n;

    initial begin
        dq_in       = 8'h00;
        mode        = MODE_IDLE;
        polls_left  = 8'h00;
        id_addr     = 8'h00;
        id_idx      = 2'd0;
        overlap_cnt = 0;
    end

    function automatic logic [7:0] id_byte(input logic [7:0] addr, input logic [1:0] idx);
        case (addr)
            8'h00:   return manuf_id[idx*8 +: 8];
            8'h20:   return sig_id[idx*8 +: 8];
            default: return 8'h00;
        endcase
    endfunction

    // Commands and addresses are latched on the rising edge of we_n.
    always @(posedge we_n) begin
        if (nand_pins.ce_n === 1'b0 && nand_pins.cle) begin
            case (nand_pins.dq_out)
                OP_RESET: begin
                    mode       = MODE_IDLE;
                    polls_left = busy_polls;
                end
                OP_STATUS:  mode = MODE_STATUS;
                OP_READ_ID: mode = MODE_ID;
                default:    mode = MODE_IDLE;
            endcase
        end else if (nand_pins.ce_n === 1'b0 && nand_pins.ale) begin
            id_addr = nand_pins.dq_out;
            id_idx  = 2'd0;
        end
    end

    always @(negedge re_n) begin
        if (nand_pins.ce_n === 1'b0) begin
            case (mode)
                MODE_STATUS: dq_in = (polls_left == 8'h00) ? STATUS_READY : STATUS_BUSY;
                MODE_ID:     dq_in = id_byte(id_addr, id_idx);
                default:     dq_in = 8'h00;
            endcase
        end
    end

    // A read ends on the rising edge of re_n.
    always @(posedge re_n) begin
        if (nand_pins.ce_n === 1'b0) begin
            if (mode == MODE_STATUS && polls_left != 8'h00) begin
                polls_left = polls_left - 8'h01;
            end
            if (mode == MODE_ID) begin
                id_idx = id_idx + 2'd1;
            end
        end
    end

    always @(we_n or re_n) begin
        if (we_n === 1'b0 && re_n === 1'b0) begin
            overlap_cnt = overlap_cnt + 1;
        end
    end

endmodule

// ==== dv/tb_nand_id.sv ====
// Runs a table of read-ID requests against the behavioural NAND model.
// Each sequence must finish within SEQ_CYCLES clocks or the test counts as stuck.
`timescale 1ns/1ps
`include "nand_defs.svh"

module tb_nand_id;

    localparam int          NUM_ROWS  = 4;
    localparam int          ACK_LIMIT = 16;
    localparam int          POLL_BITS = $clog2(`NAND_POLL_MAX);
    localparam int          T_CYC     = `NAND_T_SETUP + `NAND_T_PULSE + `NAND_T_HOLD;
    // Worst case is a full poll run with every status read busy, plus the ID phase.
    localparam int          SEQ_CYCLES = (3 + 2 * `NAND_POLL_MAX + `NAND_ID_BYTES)
                                         * (T_CYC + 2) + 64;
    localparam int          WATCHDOG_CYCLES = (NUM_ROWS + 2) * SEQ_CYCLES + 20;
    localparam logic [31:0] MANUF_ID = 32'h9590da2c;
    localparam logic [31:0] SIG_ID   = 32'h49464e4f;
    localparam int          ST_BUSY  = 0;
    localparam int          ST_DONE  = 1;
    localparam int          ST_TMO   = 2;
    localparam int          ST_BYTE  = 8;

    typedef struct packed {
        logic [7:0]  id_addr;
        logic [7:0]  polls;
        logic        rand_polls;
        logic [31:0] id_exp;
        logic        timeout_exp;
        logic        second_start;
    } row_t;

    logic                 clk;
    logic                 arst_n;
    wb_pkg::wb_req_t      wb_req;
    wb_pkg::wb_rsp_t      wb_rsp;
    nand_pkg::nand_pins_t nand_pins;
    logic [7:0]           dq_in;
    logic [7:0]           model_polls;
    int                   overlap_cnt;
    row_t                 table_rows [NUM_ROWS];
    string                row_names [NUM_ROWS];
    logic [15:0]          lfsr = 16'd23102;
    int                   cycle_cnt = 0;
    int                   errors = 0;
    int                   checks = 0;
    int                   tests = 0;

    nand_id_top i_nand_id_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .nand_pins (nand_pins),
        .dq_in     (dq_in)
    );

    nand_flash_model i_flash (
        .nand_pins   (nand_pins),
        .dq_in       (dq_in),
        .busy_polls  (model_polls),
        .manuf_id    (MANUF_ID),
        .sig_id      (SIG_ID),
        .overlap_cnt (overlap_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // ****************************************
    // Helpers
    // ****************************************

    function automatic logic [31:0] id_for(input logic [7:0] addr);
        case (addr)
            8'h00:   return MANUF_ID;
            8'h20:   return SIG_ID;
            default: return 32'h0;
        endcase
    endfunction

    // Galois LFSR stepped once for every bit taken.
    task automatic take_bits(input int n, output int val);
        logic lsb;
        val = 0;
        for (int b = 0; b < n; b++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 16'hb400;
            end
            val = (val << 1) | lsb;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("%-18s %0d error(s)", name, errors - err_before);
    endtask

    task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        rdat   = 32'h0;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk);
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            $display("ERROR: no Wishbone ack for access to address %0d", adr);
            errors++;
        end
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    task automatic wait_finish(input string name, output logic ok);
        logic [31:0] st;
        int          start_cycle;
        ok          = 1'b0;
        start_cycle = cycle_cnt;
        while (!ok && (cycle_cnt - start_cycle) < SEQ_CYCLES) begin
            wb_read(wb_pkg::REG_STATUS, st);
            ok = st[ST_DONE] && !st[ST_BUSY];
        end
        if (!ok) begin
            $display("ERROR: %s did not finish within %0d cycles", name, SEQ_CYCLES);
            errors++;
        end
    endtask

    // ****************************************
    // Tests
    // ****************************************

    task automatic load_table();
        row_names[0]  = "addr00_rand_polls";
        table_rows[0] = '{8'h00, 8'd0, 1'b1, id_for(8'h00), 1'b0, 1'b0};
        row_names[1]  = "addr20_signature";
        table_rows[1] = '{8'h20, 8'd2, 1'b0, id_for(8'h20), 1'b0, 1'b0};
        // The timeout row keeps the ID left by the row before it.
        row_names[2]  = "poll_timeout";
        table_rows[2] = '{8'h00, 8'(`NAND_POLL_MAX + 3), 1'b0, id_for(8'h20), 1'b1, 1'b0};
        row_names[3]  = "start_while_busy";
        table_rows[3] = '{8'h00, 8'd3, 1'b0, id_for(8'h00), 1'b0, 1'b1};
    endtask

    task automatic check_reset_state();
        logic [31:0] rd;
        int          err_before;
        err_before = errors;
        check_value("after_reset.pins", 32'b100110, {nand_pins.ce_n, nand_pins.cle,
                    nand_pins.ale, nand_pins.we_n, nand_pins.re_n, nand_pins.dq_oe});
        wb_read(wb_pkg::REG_CTRL, rd);
        check_value("after_reset.ctrl", 32'h0, rd);
        wb_read(wb_pkg::REG_STATUS, rd);
        check_value("after_reset.status", 32'h0, rd);
        wb_read(wb_pkg::REG_ID, rd);
        check_value("after_reset.id", 32'h0, rd);
        report_test("after_reset", err_before);
    endtask

    task automatic run_row(input int i);
        row_t        r;
        string       name;
        int          err_before;
        int          polls;
        logic [31:0] rd;
        logic        ok;
        r          = table_rows[i];
        name       = row_names[i];
        err_before = errors;
        polls      = r.polls;
        if (r.rand_polls) begin
            take_bits(POLL_BITS, polls);
            polls = polls % `NAND_POLL_MAX;
        end
        @(negedge clk);
        model_polls = 8'(polls);
        wb_write(wb_pkg::REG_CTRL, {16'h0, r.id_addr, 8'h01});
        if (r.second_start) begin
            wb_read(wb_pkg::REG_STATUS, rd);
            check_value({name, ".busy"}, 32'h1, rd[ST_BUSY]);
            wb_write(wb_pkg::REG_CTRL, {16'h0, r.id_addr ^ 8'h20, 8'h01});
        end
        wait_finish(name, ok);
        if (ok) begin
            wb_read(wb_pkg::REG_STATUS, rd);
            check_value({name, ".timeout"}, r.timeout_exp, rd[ST_TMO]);
            check_value({name, ".ready_bit"}, !r.timeout_exp, rd[ST_BYTE + 6]);
            wb_read(wb_pkg::REG_ID, rd);
            check_value({name, ".id"}, r.id_exp, rd);
        end
        report_test(name, err_before);
    endtask

    task automatic check_id_write(input logic [31:0] id_exp);
        logic [31:0] rd;
        int          err_before;
        err_before = errors;
        wb_write(wb_pkg::REG_ID, ~id_exp);
        wb_read(wb_pkg::REG_ID, rd);
        check_value("id_write.id", id_exp, rd);
        check_value("id_write.strobe_overlap", 32'h0, overlap_cnt);
        report_test("id_write", err_before);
    endtask

    initial begin
        wb_req      = '0;
        arst_n      = 1'b0;
        model_polls = 8'h00;
        load_table();
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        check_reset_state();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        check_id_write(table_rows[NUM_ROWS-1].id_exp);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hdl/nand_pkg.sv
hdl/wb_pkg.sv
hdl/nand_phy.sv
hdl/nand_id_seq.sv
hdl/nand_wb_regs.sv
hdl/nand_id_top.sv
dv/nand_flash_model.sv
dv/tb_nand_id.sv
